// ==== Makefile ====
# Verilator build and run of the read test engine testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f mem_read_test.f --top-module mem_read_test_tb -Mdir obj_dir
	./obj_dir/Vmem_read_test_tb

clean:
	rm -rf obj_dir

// ==== logic/mem_read_test.sv ====
/*
 * Top level of the read test engine, config to control to address
 * generation to issue, with response statistics feeding back
 */

`timescale 1ns/100ps

module mem_read_test
    import mem_read_test_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  t_csr_wr csr_wr,
    input  t_csr_idx csr_rd_idx,
    input  t_rd_rsp rd_rsp,
    input  logic alm_full,
    output logic [63:0] csr_rd_data,
    output t_rd_req rd_req,
    output logic busy,
    output logic run_done,
    output t_run_status run_status
);

    t_run_cfg cfg;
    t_counter run_cycles;
    logic start;
    t_run_state state;
    logic reads_enabled;
    logic issue;
    t_line_addr offset;
    t_req_cnt inflight_now;
    t_run_status stats_status;
    t_counter cycles_executed;

    // ========================================================================
    // Stages
    // ========================================================================

    test_config_regs test_config_regs_inst (
        .clk(clk), .reset(reset), .csr_wr(csr_wr), .csr_rd_idx(csr_rd_idx),
        .status(run_status), .state(state), .inflight_max(run_status.inflight_max),
        .alm_full(alm_full), .cfg(cfg), .run_cycles(run_cycles), .start(start),
        .csr_rd_data(csr_rd_data));

    run_control run_control_inst (
        .clk(clk), .reset(reset), .start(start), .run_cycles(run_cycles),
        .cfg_enable_reads(cfg.enable_reads), .inflight_now(inflight_now),
        .req_valid(rd_req.valid), .state(state), .reads_enabled(reads_enabled),
        .busy(busy), .run_done(run_done), .cycles_executed(cycles_executed));

    stride_addr_gen stride_addr_gen_inst (
        .clk(clk), .reset(reset), .start(start), .issue(issue), .cfg(cfg),
        .offset(offset));

    read_req_issue read_req_issue_inst (
        .clk(clk), .reset(reset), .start(start), .reads_enabled(reads_enabled),
        .alm_full(alm_full), .inflight_now(inflight_now), .cfg(cfg),
        .offset(offset), .issue(issue), .rd_req(rd_req));

    read_rsp_stats read_rsp_stats_inst (
        .clk(clk), .reset(reset), .start(start), .issue(issue), .rd_rsp(rd_rsp),
        .busy(busy), .inflight_now(inflight_now), .status(stats_status));

    // Status record, stats plus the FSM cycle count
    always_comb
    begin
        run_status = stats_status;
        run_status.cycles_executed = cycles_executed;
    end

endmodule

// ==== logic/mem_read_test_pkg.sv ====
/*
 * Shared widths, register indices, enums and packed structs
 * for the host memory read test engine
 */

package mem_read_test_pkg;

    // ========================================================================
    // Sizes and register map
    // ========================================================================

    // Line address width on the host interface
    localparam int LINE_ADDR_BITS = 42;

    // Allocated buffer size as address bits, reported through read index 0
    localparam int N_MEM_REGION_BITS = 24;

    localparam int NUM_CSRS = 8;
    localparam int CSR_IDX_BITS = $clog2(NUM_CSRS);

    typedef logic [CSR_IDX_BITS-1:0] t_csr_idx;

    // Write indices
    localparam t_csr_idx CSR_RUN_CYCLES = 3'd0;
    localparam t_csr_idx CSR_RD_BASE = 3'd1;
    localparam t_csr_idx CSR_MEM_MASK = 3'd2;
    localparam t_csr_idx CSR_RUN_CFG = 3'd3;
    localparam t_csr_idx CSR_CREDITS = 3'd4;

    // Read indices, anything above CSR_RD_CYCLES reads as zero
    localparam t_csr_idx CSR_RD_REGION = 3'd0;
    localparam t_csr_idx CSR_RD_BASE_RB = 3'd1;
    localparam t_csr_idx CSR_RD_RSP_CNT = 3'd2;
    localparam t_csr_idx CSR_RD_STATE = 3'd3;
    localparam t_csr_idx CSR_RD_INFLIGHT_MAX = 3'd4;
    localparam t_csr_idx CSR_RD_CYCLES = 3'd5;

    // ========================================================================
    // Scalar types
    // ========================================================================

    typedef logic [LINE_ADDR_BITS-1:0] t_line_addr;
    typedef logic [15:0] t_stride;
    typedef logic [31:0] t_counter;
    typedef logic [10:0] t_req_cnt;
    typedef logic [63:0] t_total;
    typedef logic [15:0] t_mdata;

    // Encoded value is the number of lines minus one
    typedef enum logic [1:0]
    {
        CL_LEN_1 = 2'd0,
        CL_LEN_2 = 2'd1,
        CL_LEN_4 = 2'd3
    } t_cl_len;

    typedef enum logic
    {
        RD_LINE_I = 1'b0,
        RD_LINE_S = 1'b1
    } t_rd_mode;

    typedef enum logic [1:0]
    {
        RUN_IDLE = 2'd0,
        RUN_ACTIVE = 2'd1,
        RUN_DRAIN = 2'd2
    } t_run_state;

    // ========================================================================
    // Records
    // ========================================================================

    typedef struct packed
    {
        logic en;
        t_csr_idx idx;
        logic [63:0] data;
    } t_csr_wr;

    typedef struct packed
    {
        t_line_addr rd_base;
        t_line_addr mem_mask;
        t_stride stride;
        t_cl_len cl_len;
        t_rd_mode rd_mode;
        logic enable_reads;
        t_req_cnt credits;
    } t_run_cfg;

    typedef struct packed
    {
        logic valid;
        t_line_addr addr;
        t_mdata mdata;
        t_cl_len cl_len;
        t_rd_mode rd_mode;
    } t_rd_req;

    // One pulse per returned line, eop on the last line of a request
    typedef struct packed
    {
        logic valid;
        t_mdata mdata;
        logic eop;
    } t_rd_rsp;

    typedef struct packed
    {
        t_counter cycles_executed;
        t_counter rsp_lines;
        t_req_cnt inflight_max;
        t_total inflight_total;
    } t_run_status;

endpackage

// ==== logic/read_req_issue.sv ====
/*
 * Read request gating on almost-full, credits and enable,
 * and the registered outgoing request
 */

`timescale 1ns/100ps

module read_req_issue
    import mem_read_test_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic reads_enabled,
    input  logic alm_full,
    input  t_req_cnt inflight_now,
    input  t_run_cfg cfg,
    input  t_line_addr offset,
    output logic issue,
    output t_rd_req rd_req
);

    // Registered almost-full, stops issue one cycle after the rise
    logic alm_full_q;

    // Credit check from the previous cycle's in-flight count
    logic credit_ok;

    // Request tag, one step per request
    t_mdata tag;

    always_ff @(posedge clk)
    begin
        alm_full_q <= alm_full;
        credit_ok <= (inflight_now < cfg.credits);

        if (reset)
        begin
            // Hold off until the first real sample
            alm_full_q <= 1'b1;
            credit_ok <= 1'b0;
        end
    end

    assign issue = reads_enabled && !alm_full_q && credit_ok;

    // ========================================================================
    // Outgoing request
    // ========================================================================

    always_ff @(posedge clk)
    begin
        rd_req.valid <= issue;
        rd_req.addr <= cfg.rd_base + offset;
        rd_req.mdata <= tag;
        rd_req.cl_len <= cfg.cl_len;
        rd_req.rd_mode <= cfg.rd_mode;

        if (issue)
        begin
            tag <= tag + t_mdata'(1);
        end

        if (reset || start)
        begin
            tag <= t_mdata'(0);
        end

        if (reset)
        begin
            rd_req.valid <= 1'b0;
        end
    end

    // Exactly one request per issue pulse, one cycle later
    assert property (@(posedge clk) disable iff (reset)
        rd_req.valid == $past(issue));

endmodule

// ==== logic/read_rsp_stats.sv ====
/*
 * Response line counter and in-flight now, max and total statistics
 */

`timescale 1ns/100ps

module read_rsp_stats
    import mem_read_test_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic issue,
    input  t_rd_rsp rd_rsp,
    input  logic busy,
    output t_req_cnt inflight_now,
    output t_run_status status
);

    // Responses registered before counting
    logic rsp_q;
    logic eop_q;

    t_counter rsp_lines;
    t_req_cnt inflight_max;

    // Little's Law sum, average latency is total over response count
    t_total inflight_total;

    always_ff @(posedge clk)
    begin
        rsp_q <= rd_rsp.valid;
        eop_q <= rd_rsp.valid && rd_rsp.eop;

        if (rsp_q)
        begin
            rsp_lines <= rsp_lines + t_counter'(1);
        end

        // Issue and eop in the same cycle cancel out
        if (issue != eop_q)
        begin
            inflight_now <= eop_q ? inflight_now - t_req_cnt'(1) :
                                    inflight_now + t_req_cnt'(1);
        end

        if (inflight_now > inflight_max)
        begin
            inflight_max <= inflight_now;
        end

        if (busy)
        begin
            inflight_total <= inflight_total + t_total'(inflight_now);
        end

        if (reset || start)
        begin
            rsp_q <= 1'b0;
            eop_q <= 1'b0;
            rsp_lines <= t_counter'(0);
            inflight_now <= t_req_cnt'(0);
            inflight_max <= t_req_cnt'(0);
            inflight_total <= t_total'(0);
        end
    end

    // Cycle count comes from the FSM and is merged at the top
    always_comb
    begin
        status.cycles_executed = t_counter'(0);
        status.rsp_lines = rsp_lines;
        status.inflight_max = inflight_max;
        status.inflight_total = inflight_total;
    end

    // An eop always belongs to a request that was counted earlier
    assert property (@(posedge clk) disable iff (reset)
        (eop_q && !issue) |-> (inflight_now != t_req_cnt'(0)));

endmodule

// ==== logic/run_control.sv ====
/*
 * Idle, run and drain FSM with the run length countdown
 * and the executed cycle counter
 */

`timescale 1ns/100ps

module run_control
    import mem_read_test_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  t_counter run_cycles,
    input  logic cfg_enable_reads,
    input  t_req_cnt inflight_now,
    input  logic req_valid,
    output t_run_state state,
    output logic reads_enabled,
    output logic busy,
    output logic run_done,
    output t_counter cycles_executed
);

    // Cycles left in the active phase
    t_counter remaining;

    // Nothing outstanding and nothing leaving on the request port
    logic drain_done;

    assign drain_done = (inflight_now == t_req_cnt'(0)) && !req_valid;
    assign busy = (state != RUN_IDLE);

    always_ff @(posedge clk)
    begin
        run_done <= 1'b0;

        case (state)
            RUN_IDLE:
            begin
                if (start)
                begin
                    state <= RUN_ACTIVE;
                    remaining <= run_cycles;
                    reads_enabled <= cfg_enable_reads;
                    cycles_executed <= t_counter'(0);
                end
            end

            RUN_ACTIVE:
            begin
                cycles_executed <= cycles_executed + t_counter'(1);

                // Countdown expired, stop issuing and wait for responses
                if (remaining == t_counter'(0))
                begin
                    state <= RUN_DRAIN;
                    reads_enabled <= 1'b0;
                end
                else
                begin
                    remaining <= remaining - t_counter'(1);
                end
            end

            RUN_DRAIN:
            begin
                cycles_executed <= cycles_executed + t_counter'(1);

                if (drain_done)
                begin
                    state <= RUN_IDLE;
                    run_done <= 1'b1;
                end
            end

            default:
            begin
                state <= RUN_IDLE;
            end
        endcase

        if (reset)
        begin
            state <= RUN_IDLE;
            reads_enabled <= 1'b0;
            run_done <= 1'b0;
            remaining <= t_counter'(0);
            cycles_executed <= t_counter'(0);
        end
    end

    // Done only after the issue enable was dropped and the FSM is back in idle
    assert property (@(posedge clk) disable iff (reset)
        run_done |-> (!reads_enabled && (state == RUN_IDLE)));

endmodule

// ==== logic/stride_addr_gen.sv ====
/*
 * Strided read offset generator with wrap to a rotating start base
 */

`timescale 1ns/100ps

module stride_addr_gen
    import mem_read_test_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic issue,
    input  t_run_cfg cfg,
    output t_line_addr offset
);

    // Start base used at the next buffer wrap
    t_stride base;

    // Lines per request, the base step
    t_stride base_step;

    // Largest start base, keeps the footprint inside one stride
    t_stride base_max;

    // One extra bit so the step never rolls over the compare
    logic [$bits(t_stride):0] base_sum;

    t_line_addr offset_next;
    logic next_wraps;

    always_comb
    begin
        base_step = t_stride'(cfg.cl_len) + t_stride'(1);

        // Zero stride pins the base at the buffer head
        if (cfg.stride == t_stride'(0))
        begin
            base_max = t_stride'(0);
        end
        else
        begin
            base_max = (cfg.stride - base_step) & t_stride'(cfg.mem_mask);
        end

        base_sum = {1'b0, base} + {1'b0, base_step};

        offset_next = offset + t_line_addr'(cfg.stride);

        // Any bit above the mask means the stride ran off the buffer
        next_wraps = |(offset_next & ~cfg.mem_mask);
    end

    // ========================================================================
    // Offset and rotating base
    // ========================================================================

    always_ff @(posedge clk)
    begin
        if (issue)
        begin
            if (next_wraps)
            begin
                // Back to the head, shifted so every stride sees the same lines
                offset <= t_line_addr'(base);

                if (base_sum > {1'b0, base_max})
                begin
                    base <= t_stride'(0);
                end
                else
                begin
                    base <= base_sum[$bits(t_stride)-1:0];
                end
            end
            else
            begin
                offset <= offset_next;
            end
        end

        if (reset || start)
        begin
            offset <= t_line_addr'(0);
            base <= t_stride'(0);
        end
    end

    // Every issued read lands inside the buffer
    assert property (@(posedge clk) disable iff (reset)
        issue |-> ((offset & ~cfg.mem_mask) == t_line_addr'(0)));

endmodule

// ==== logic/test_config_regs.sv ====
/*
 * Host register write decode into the run configuration,
 * start pulse generation and the register read mux
 */

`timescale 1ns/100ps

module test_config_regs
    import mem_read_test_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  t_csr_wr csr_wr,
    input  t_csr_idx csr_rd_idx,
    input  t_run_status status,
    input  t_run_state state,
    input  t_req_cnt inflight_max,
    input  logic alm_full,
    output t_run_cfg cfg,
    output t_counter run_cycles,
    output logic start,
    output logic [63:0] csr_rd_data
);

    // ========================================================================
    // Register writes
    // ========================================================================

    always_ff @(posedge clk)
    begin
        if (csr_wr.en && (csr_wr.idx == CSR_RD_BASE))
        begin
            cfg.rd_base <= t_line_addr'(csr_wr.data);
        end

        if (csr_wr.en && (csr_wr.idx == CSR_MEM_MASK))
        begin
            cfg.mem_mask <= t_line_addr'(csr_wr.data);
        end

        // Packed run word, enable in bit 0 and stride on top
        if (csr_wr.en && (csr_wr.idx == CSR_RUN_CFG))
        begin
            cfg.enable_reads <= csr_wr.data[0];
            cfg.rd_mode <= t_rd_mode'(csr_wr.data[1]);
            cfg.cl_len <= t_cl_len'(csr_wr.data[3:2]);
            cfg.stride <= csr_wr.data[19:4];
        end

        if (csr_wr.en && (csr_wr.idx == CSR_CREDITS))
        begin
            cfg.credits <= t_req_cnt'(csr_wr.data);
        end

        // Run length write also kicks off the run
        if (csr_wr.en && (csr_wr.idx == CSR_RUN_CYCLES))
        begin
            run_cycles <= t_counter'(csr_wr.data);
        end

        start <= csr_wr.en && (csr_wr.idx == CSR_RUN_CYCLES);

        if (reset)
        begin
            start <= 1'b0;
            cfg.enable_reads <= 1'b0;
            // No limit on outstanding reads until the host sets one
            cfg.credits <= ~t_req_cnt'(0);
        end
    end

    // ========================================================================
    // Register reads
    // ========================================================================

    always_comb
    begin
        case (csr_rd_idx)
            CSR_RD_REGION: csr_rd_data = 64'(N_MEM_REGION_BITS);
            CSR_RD_BASE_RB: csr_rd_data = 64'(cfg.rd_base);
            CSR_RD_RSP_CNT: csr_rd_data = 64'(status.rsp_lines);
            // Raw almost-full in bit 0, FSM state in bits 15:8
            CSR_RD_STATE: csr_rd_data = {48'(0), 8'(state), 7'(0), alm_full};
            CSR_RD_INFLIGHT_MAX: csr_rd_data = 64'(inflight_max);
            CSR_RD_CYCLES: csr_rd_data = 64'(status.cycles_executed);
            default: csr_rd_data = 64'(0);
        endcase
    end

    // Host only writes the defined slots
    assert property (@(posedge clk) disable iff (reset)
        csr_wr.en |-> (csr_wr.idx <= CSR_CREDITS));

endmodule

// ==== mem_read_test.f ====
logic/mem_read_test_pkg.sv
logic/test_config_regs.sv
logic/run_control.sv
logic/stride_addr_gen.sv
logic/read_req_issue.sv
logic/read_rsp_stats.sv
logic/mem_read_test.sv
tb/mem_read_test_tb.sv

// ==== tb/mem_read_test_tb.sv ====
/*
 * Testbench for the read test engine: clock, reset, data file steps,
 * memory responder, address model and result checks
 */

`timescale 1ns/100ps

module mem_read_test_tb
    import mem_read_test_pkg::*;
();

    localparam int RUN_TIMEOUT = 20000;
    localparam int STEP_WORDS = 9;

    logic clk;
    logic reset;
    t_csr_wr csr_wr;
    t_csr_idx csr_rd_idx;
    t_rd_rsp rd_rsp;
    logic alm_full;
    logic [63:0] csr_rd_data;
    t_rd_req rd_req;
    logic busy;
    logic run_done;
    t_run_status run_status;

    // Word 0 is the step count, then STEP_WORDS words per step
    logic [63:0] testdata [0:127];

    // Current step, written only while the engine is idle
    t_line_addr cur_base;
    t_line_addr cur_mask;
    t_stride cur_stride;
    t_rd_mode cur_mode;
    int cur_cl;
    int cur_credits;
    int cur_lat_max;
    int af_start;
    int af_len;
    logic [63:0] exp_lines;

    // Monitor state, cleared when a run length write is seen
    int seed;
    int tb_cycle;
    int run_cycle;
    int af_hold;
    logic in_run;
    t_counter reqs_seen;
    t_counter lines_seen;
    t_counter eops_sent;
    t_counter busy_cycles;
    t_counter done_count;
    t_mdata exp_tag;
    t_line_addr model_offset;
    int model_base;

    // In-flight model, an eop counts until its registered copy has been seen
    t_counter eops_retired;
    t_counter model_inflight;
    t_req_cnt model_max;
    t_total model_total;
    int eop_cycles[$];

    // Responder queue, one entry per returned line
    int rsp_due[$];
    t_mdata rsp_tag[$];
    logic rsp_eop[$];

    int step_count;
    int widx;
    int latency;
    t_run_status captured;
    logic [63:0] rd_value;

    mem_read_test mem_read_test_inst (
        .clk(clk), .reset(reset), .csr_wr(csr_wr), .csr_rd_idx(csr_rd_idx),
        .rd_rsp(rd_rsp), .alm_full(alm_full), .csr_rd_data(csr_rd_data),
        .rd_req(rd_req), .busy(busy), .run_done(run_done),
        .run_status(run_status));

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ========================================================================
    // Failure reporting and compare tasks
    // ========================================================================

    task end_with_failure();
        begin
            $display("=== FAIL ===");
            $fatal(1, "Simulation stopped at the first error");
        end
    endtask

    task automatic check_addr(input string name, input t_line_addr actual,
                              input t_line_addr expected);
        begin
            if (actual !== expected)
            begin
                $display("FAILED %s: got %h expected %h", name, actual, expected);
                end_with_failure();
            end
        end
    endtask

    task automatic check_counter(input string name, input t_counter actual,
                                 input t_counter expected);
        begin
            if (actual !== expected)
            begin
                $display("FAILED %s: got %h expected %h", name, actual, expected);
                end_with_failure();
            end
        end
    endtask

    task automatic check_req_cnt(input string name, input t_req_cnt actual,
                                 input t_req_cnt expected);
        begin
            if (actual !== expected)
            begin
                $display("FAILED %s: got %h expected %h", name, actual, expected);
                end_with_failure();
            end
        end
    endtask

    task automatic check_mdata(input string name, input t_mdata actual,
                               input t_mdata expected);
        begin
            if (actual !== expected)
            begin
                $display("FAILED %s: got %h expected %h", name, actual, expected);
                end_with_failure();
            end
        end
    endtask

    task automatic check_data(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
        begin
            if (actual !== expected)
            begin
                $display("FAILED %s: got %h expected %h", name, actual, expected);
                end_with_failure();
            end
        end
    endtask

    // ========================================================================
    // Host register access, called right after a rising edge
    // ========================================================================

    task automatic write_reg(input t_csr_idx idx, input logic [63:0] data);
        begin
            csr_wr <= {1'b1, idx, data};
            @(posedge clk);
            csr_wr <= '0;
        end
    endtask

    task automatic read_reg(input t_csr_idx idx, output logic [63:0] data);
        begin
            csr_rd_idx <= idx;
            @(posedge clk);
            data = csr_rd_data;
        end
    endtask

    task automatic load_step(input int s);
        begin
            widx = 1 + s * STEP_WORDS;
            cur_base = t_line_addr'(testdata[widx]);
            cur_mask = t_line_addr'(testdata[widx + 1]);
            // Run word holds enable, mode, cl_len and stride from bit 0
            cur_stride = t_stride'(testdata[widx + 2][19:4]);
            cur_mode = t_rd_mode'(testdata[widx + 2][1]);
            cur_cl = int'(testdata[widx + 2][3:2]);
            cur_credits = int'(testdata[widx + 3][10:0]);
            cur_lat_max = int'(testdata[widx + 5][15:0]);
            af_start = int'(testdata[widx + 6][15:0]);
            af_len = int'(testdata[widx + 7][15:0]);
            exp_lines = testdata[widx + 8];
        end
    endtask

    // Poll for the done pulse and keep the status seen with it
    task automatic wait_run_done(output t_run_status status);
        int waited;
        begin
            waited = 0;
            do
            begin
                @(posedge clk);
                waited = waited + 1;
                if (waited > RUN_TIMEOUT)
                begin
                    $display("Timeout: run_done did not pulse within %0d cycles",
                             RUN_TIMEOUT);
                    end_with_failure();
                end
            end
            while (run_done !== 1'b1);
            status = run_status;
        end
    endtask

    // Stride walk, wrap to the rotating base, base wraps past its limit
    task automatic advance_address_model();
        t_line_addr next_off;
        int limit;
        begin
            next_off = model_offset + t_line_addr'(cur_stride);
            if ((next_off & ~cur_mask) != t_line_addr'(0))
            begin
                model_offset = t_line_addr'(model_base);
                if (cur_stride == t_stride'(0))
                begin
                    limit = 0;
                end
                else
                begin
                    limit = int'((cur_stride - t_stride'(cur_cl + 1)) & t_stride'(cur_mask));
                end
                model_base = (model_base + cur_cl + 1 > limit) ? 0 : model_base + cur_cl + 1;
            end
            else
            begin
                model_offset = next_off;
            end
        end
    endtask

    // ========================================================================
    // Monitor and memory responder
    // ========================================================================

    initial
    begin
        rd_rsp = '0;
        alm_full = 1'b0;
        seed = 32'hfdcf_9b43;
        tb_cycle = 0;
        run_cycle = 0;
        af_hold = 0;
        in_run = 1'b0;
        forever
        begin
            @(posedge clk);
            tb_cycle = tb_cycle + 1;

            // Run length write seen by the DUT on this edge
            if (csr_wr.en && (csr_wr.idx == CSR_RUN_CYCLES))
            begin
                in_run = 1'b1;
                run_cycle = 0;
                reqs_seen = '0;
                lines_seen = '0;
                eops_sent = '0;
                busy_cycles = '0;
                done_count = '0;
                exp_tag = '0;
                model_offset = '0;
                model_base = 0;
                eops_retired = '0;
                model_max = '0;
                model_total = '0;
                eop_cycles.delete();
            end

            if (busy === 1'b1)
            begin
                busy_cycles = busy_cycles + t_counter'(1);
            end
            af_hold = alm_full ? af_hold + 1 : 0;

            if (rd_req.valid === 1'b1)
            begin
                // Two requests may still slip out after the rise
                if (af_hold >= 3)
                begin
                    $display("Read request issued on cycle %0d of an almost-full hold",
                             af_hold);
                    end_with_failure();
                end
                check_addr("rd_req.addr", rd_req.addr, cur_base + model_offset);
                check_mdata("rd_req.mdata", rd_req.mdata, exp_tag);
                check_data("rd_req.cl_len", 64'(rd_req.cl_len), 64'(cur_cl));
                check_data("rd_req.rd_mode", 64'(rd_req.rd_mode), 64'(cur_mode));
                advance_address_model();
                exp_tag = exp_tag + t_mdata'(1);
                reqs_seen = reqs_seen + t_counter'(1);
                lines_seen = lines_seen + t_counter'(cur_cl + 1);
                latency = 1 + int'($unsigned($random(seed)) % cur_lat_max);
                for (int i = 0; i <= cur_cl; i++)
                begin
                    rsp_due.push_back(tb_cycle + latency);
                    rsp_tag.push_back(rd_req.mdata);
                    rsp_eop.push_back(i == cur_cl);
                end
            end

            // Credit gate is one cycle late, so one extra is allowed
            if (int'(reqs_seen - eops_sent) > cur_credits + 1)
            begin
                $display("Outstanding reads %0d exceed the credit limit %0d plus one",
                         int'(reqs_seen - eops_sent), cur_credits);
                end_with_failure();
            end

            // Eop on the bus next cycle, registered the cycle after, then counted down
            while ((eop_cycles.size() > 0) && (eop_cycles[0] + 3 <= tb_cycle))
            begin
                void'(eop_cycles.pop_front());
                eops_retired = eops_retired + t_counter'(1);
            end
            model_inflight = reqs_seen - eops_retired;

            // Little's Law sum and peak over the busy cycles
            if (busy === 1'b1)
            begin
                model_total = model_total + t_total'(model_inflight);
                if (t_req_cnt'(model_inflight) > model_max)
                begin
                    model_max = t_req_cnt'(model_inflight);
                end
            end

            if (run_done === 1'b1)
            begin
                if (done_count != t_counter'(0))
                begin
                    $display("run_done pulsed more than once in one run");
                    end_with_failure();
                end
                done_count = done_count + t_counter'(1);
                in_run = 1'b0;
            end

            // In-order return, one line per cycle once the head is due
            if ((rsp_due.size() > 0) && (rsp_due[0] <= tb_cycle))
            begin
                rd_rsp <= {1'b1, rsp_tag[0], rsp_eop[0]};
                if (rsp_eop[0])
                begin
                    eops_sent = eops_sent + t_counter'(1);
                    eop_cycles.push_back(tb_cycle);
                end
                void'(rsp_due.pop_front());
                void'(rsp_tag.pop_front());
                void'(rsp_eop.pop_front());
            end
            else
            begin
                rd_rsp <= '0;
            end

            alm_full <= in_run && (run_cycle >= af_start) && (run_cycle < af_start + af_len);
            if (in_run)
            begin
                run_cycle = run_cycle + 1;
            end
        end
    end

    // ========================================================================
    // Test steps
    // ========================================================================

    initial
    begin
        reset = 1'b1;
        csr_wr = '0;
        csr_rd_idx = '0;
        $readmemh("tb/mem_read_test_testdata.txt", testdata);
        step_count = int'(testdata[0][7:0]);
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        for (int s = 0; s < step_count; s++)
        begin
            load_step(s);
            write_reg(CSR_RD_BASE, testdata[widx]);
            write_reg(CSR_MEM_MASK, testdata[widx + 1]);
            write_reg(CSR_RUN_CFG, testdata[widx + 2]);
            write_reg(CSR_CREDITS, testdata[widx + 3]);

            // Read-back while idle
            read_reg(CSR_RD_REGION, rd_value);
            check_data("region bits", rd_value, 64'(N_MEM_REGION_BITS));
            read_reg(CSR_RD_BASE_RB, rd_value);
            check_data("read base", rd_value, 64'(cur_base));
            read_reg(CSR_RD_STATE, rd_value);
            check_data("state", rd_value, {48'h0, 8'(RUN_IDLE), 7'h0, 1'b0});

            write_reg(CSR_RUN_CYCLES, testdata[widx + 4]);
            wait_run_done(captured);
            @(negedge clk);

            // Status against what the monitor counted
            check_counter("cycles_executed", captured.cycles_executed, busy_cycles);
            check_counter("rsp_lines", captured.rsp_lines, lines_seen);
            check_counter("eops returned", eops_sent, reqs_seen);
            check_req_cnt("inflight_max", captured.inflight_max, model_max);
            check_data("inflight_total", 64'(captured.inflight_total), 64'(model_total));
            if (exp_lines != 64'hffff_ffff)
            begin
                check_data("rsp_lines from data file", 64'(captured.rsp_lines), exp_lines);
            end
            if ((int'(captured.inflight_max) < 1) ||
                (int'(captured.inflight_max) > cur_credits + 1))
            begin
                $display("In-flight maximum %0d is outside 1 to credits %0d plus one",
                         int'(captured.inflight_max), cur_credits);
                end_with_failure();
            end

            @(posedge clk);
            read_reg(CSR_RD_RSP_CNT, rd_value);
            check_data("response count register", rd_value, 64'(lines_seen));
            read_reg(CSR_RD_INFLIGHT_MAX, rd_value);
            check_req_cnt("in-flight max register", t_req_cnt'(rd_value), model_max);
            read_reg(CSR_RD_CYCLES, rd_value);
            check_counter("cycles register", t_counter'(rd_value), busy_cycles);
            repeat (3) @(posedge clk);
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== tb/mem_read_test_testdata.txt ====
// First word is the step count, then one step per line:
// rd_base mem_mask run_cfg credits run_cycles lat_max af_start af_len exp_lines
// run_cfg packs enable, mode, cl_len, stride from bit 0 upward
// exp_lines is ffffffff where the line count depends on back-pressure
6
// Stride 24 does not divide a 256 line buffer
1000 ff 181 7ff 3f 8 0 0 40
// Four lines per request, shared mode, high base
200000000 3ff 40f 7ff 1f a 0 0 80
// Zero stride stays on the buffer head
500 7f 5 7ff f 5 0 0 20
// Long latency against a small credit limit
3000 fff 255 4 7f 40 0 0 ffffffff
// Almost-full held for 20 cycles mid-run
100 1ff 133 10 5f 6 10 14 ffffffff
// Small buffer, base rotates through its limit several times
7c0 3f 10d 7ff 3f 3 0 0 100
